// ==== rtl/perf_cnt_pkg.sv ====
package perf_cnt_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int CNT_NB = 6;  // counter slots
  localparam int EVT_NB = 5;  // raw event lines from the chip
  localparam int DATA_W = 32; // register word
  localparam int ADDR_W = 3;  // slot address, covers CNT_NB

  typedef logic [DATA_W-1:0] cnt_data_t; // counter value / reg data
  typedef logic [ADDR_W-1:0] cnt_addr_t; // slot address

  // ----------------------------------------
  // counting modes
  // ----------------------------------------
  typedef enum logic [2:0] {
    PULSE,    // +1 per high cycle, saturates
    EDGE,     // +1 per rising edge, saturates
    DURATION, // longest high run seen
    LOW,      // low half of 64b pair, wraps
    HIGH      // high half, fed by carry, saturates
  } cnt_mode_e;

  // marks a slot with no event line of its own
  localparam int EVT_NONE = -1;

  // ----------------------------------------
  // per-slot tables, slot 0 first
  // ----------------------------------------
  localparam cnt_mode_e CNT_MODE [CNT_NB] = '{
    PULSE,    // slot 0
    EDGE,     // slot 1
    DURATION, // slot 2
    LOW,      // slot 3
    HIGH,     // slot 4, pairs with slot 3
    PULSE     // slot 5
  };

  localparam int CNT_EVT_IDX [CNT_NB] = '{
    0,        // slot 0
    1,        // slot 1
    2,        // slot 2
    3,        // slot 3
    EVT_NONE, // slot 4 counts the carry of slot 3
    4         // slot 5
  };

endpackage

// ==== rtl/perf_cnt_front.sv ====
`timescale 1ns/10ps

module perf_cnt_front (
  input  logic                              clk,
  input  logic                              s_rst_n,

  input  logic [perf_cnt_pkg::EVT_NB-1:0]   evt_i,   // raw levels
  input  logic                              wr_en_i, // sw write strobe
  input  perf_cnt_pkg::cnt_addr_t           wr_addr_i,
  input  perf_cnt_pkg::cnt_data_t           wr_data_i,
  input  logic                              carry_i, // wrap pulse of the LOW slot

  output logic [perf_cnt_pkg::CNT_NB-1:0]   inc_o,   // registered increments
  output logic [perf_cnt_pkg::CNT_NB-1:0]   load_o,  // registered loads
  output perf_cnt_pkg::cnt_data_t           load_data_o
);

  logic [perf_cnt_pkg::CNT_NB-1:0] inc_d;  // strobes before the register
  logic [perf_cnt_pkg::CNT_NB-1:0] load_d;

  // ----------------------------------------
  // event conditioning, one rule per slot
  // ----------------------------------------
  for (genvar gi = 0; gi < perf_cnt_pkg::CNT_NB; gi++) begin : gen_slot
    if (perf_cnt_pkg::CNT_MODE[gi] == perf_cnt_pkg::HIGH) begin : gen_high
      // no event line, counts the carry of its LOW partner
      assign inc_d[gi] = carry_i;
    end else if (perf_cnt_pkg::CNT_MODE[gi] == perf_cnt_pkg::EDGE) begin : gen_edge
      logic evt_q; // level at previous edge

      always_ff @(posedge clk) begin
        if (!s_rst_n) begin
          evt_q <= 1'b0;
        end else begin
          evt_q <= evt_i[perf_cnt_pkg::CNT_EVT_IDX[gi]];
        end
      end

      // low before, high now
      assign inc_d[gi] = evt_i[perf_cnt_pkg::CNT_EVT_IDX[gi]] & ~evt_q;
    end else begin : gen_level
      // PULSE, LOW and DURATION all take the plain level
      assign inc_d[gi] = evt_i[perf_cnt_pkg::CNT_EVT_IDX[gi]];
    end

    // one-hot write decode
    assign load_d[gi] = wr_en_i && (wr_addr_i == perf_cnt_pkg::cnt_addr_t'(gi));
  end

  // ----------------------------------------
  // strobe register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      inc_o  <= '0;
      load_o <= '0;
    end else begin
      inc_o  <= inc_d;
      load_o <= load_d;
    end
  end

  // write data, shared by all slots
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      load_data_o <= wr_data_i; // held until next write
    end
  end

  // a write must hit an existing slot, else it is silently lost
  a_wr_addr_range : assert property (
    @(posedge clk) disable iff (!s_rst_n)
    wr_en_i |-> (wr_addr_i < perf_cnt_pkg::cnt_addr_t'(perf_cnt_pkg::CNT_NB))
  ) else $error("write to slot %0d, only %0d slots", wr_addr_i, perf_cnt_pkg::CNT_NB);

endmodule

// ==== rtl/perf_cnt_slice.sv ====
`timescale 1ns/10ps

module perf_cnt_slice #(
  parameter perf_cnt_pkg::cnt_mode_e MODE = perf_cnt_pkg::PULSE, // counting rule
  parameter int                      IDX  = 0                    // slot number
) (
  input  logic                    clk,
  input  logic                    s_rst_n,

  input  logic                    inc_i,       // count strobe from the front
  input  logic                    load_i,      // sw load, wins over inc_i
  input  perf_cnt_pkg::cnt_data_t load_data_i,

  output perf_cnt_pkg::cnt_data_t value_o,     // count, or max for DURATION
  output logic                    carry_o      // wrap pulse, LOW only
);

  perf_cnt_pkg::cnt_data_t cnt;  // visible value
  logic                    cnt_full;

  assign cnt_full = (cnt == '1);

  if (MODE == perf_cnt_pkg::DURATION) begin : gen_dur
    // ----------------------------------------
    // run length and its maximum
    // ----------------------------------------
    perf_cnt_pkg::cnt_data_t run; // length of the current high run
    logic                    run_full;

    assign run_full = (run == '1);

    always_ff @(posedge clk) begin
      if (!s_rst_n) begin
        run <= '0;
        cnt <= '0;
      end else begin
        if (!inc_i) begin
          run <= '0;         // run over
        end else if (!run_full) begin
          run <= run + 1'b1; // sticks at all ones
        end

        // max follows run one edge later
        if (load_i) begin
          cnt <= load_data_i;
        end else if (run > cnt) begin
          cnt <= run;
        end
      end
    end

    assign carry_o = 1'b0;
  end else begin : gen_cnt
    // ----------------------------------------
    // plain counter
    // ----------------------------------------
    perf_cnt_pkg::cnt_data_t cnt_nxt;
    logic                    cnt_step; // counter moves this cycle

    // LOW wraps through zero, others stop at all ones
    assign cnt_step = inc_i && (!cnt_full || (MODE == perf_cnt_pkg::LOW));

    always_comb begin
      cnt_nxt = cnt;
      if (load_i) begin
        cnt_nxt = load_data_i;
      end else if (cnt_step) begin
        cnt_nxt = cnt + 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (!s_rst_n) begin
        cnt <= '0;
      end else begin
        cnt <= cnt_nxt;
      end
    end

    // pulse in the cycle that ends with the wrap to zero
    assign carry_o = (MODE == perf_cnt_pkg::LOW) && inc_i && !load_i && cnt_full;
  end

  assign value_o = cnt;

  if (MODE == perf_cnt_pkg::LOW) begin : gen_chk_low
    // carry only where the low half really wraps
    a_carry_wrap : assert property (
      @(posedge clk) disable iff (!s_rst_n)
      carry_o |=> (value_o == '0)
    ) else $error("slot %0d: carry without a wrap to zero", IDX);
  end else begin : gen_chk
    // saturated value only leaves all ones through a sw load
    a_sat_hold : assert property (
      @(posedge clk) disable iff (!s_rst_n)
      (cnt_full && !load_i) |=> $stable(value_o)
    ) else $error("slot %0d: saturated value moved without load", IDX);
  end

endmodule

// ==== rtl/perf_cnt_readback.sv ====
`timescale 1ns/10ps

module perf_cnt_readback (
  input  logic                                                 clk,
  input  logic                                                 s_rst_n,

  input  perf_cnt_pkg::cnt_data_t [perf_cnt_pkg::CNT_NB-1:0]   slot_value_i, // all slots
  input  logic                                                 rd_en_i,      // read strobe
  input  perf_cnt_pkg::cnt_addr_t                              rd_addr_i,

  output perf_cnt_pkg::cnt_data_t                              rd_data_o,
  output logic                                                 rd_valid_o    // 1 cycle
);

  perf_cnt_pkg::cnt_data_t sel_data; // addressed slot
  logic                    addr_ok;

  // ----------------------------------------
  // slot select
  // ----------------------------------------
  assign addr_ok = (rd_addr_i < perf_cnt_pkg::cnt_addr_t'(perf_cnt_pkg::CNT_NB));

  always_comb begin
    sel_data = '0; // holes in the map read zero
    if (addr_ok) begin
      sel_data = slot_value_i[rd_addr_i];
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= sel_data; // value as seen at the strobe edge
    end
  end

endmodule

// ==== rtl/perf_cnt_top.sv ====
`timescale 1ns/10ps

module perf_cnt_top (
  input  logic                            clk,
  input  logic                            s_rst_n,

  input  logic [perf_cnt_pkg::EVT_NB-1:0] evt_i,     // event levels

  input  logic                            wr_en_i,   // sw write
  input  perf_cnt_pkg::cnt_addr_t         wr_addr_i,
  input  perf_cnt_pkg::cnt_data_t         wr_data_i,

  input  logic                            rd_en_i,   // sw read
  input  perf_cnt_pkg::cnt_addr_t         rd_addr_i,
  output perf_cnt_pkg::cnt_data_t         rd_data_o,
  output logic                            rd_valid_o
);

  logic [perf_cnt_pkg::CNT_NB-1:0]                     inc;   // front -> slices
  logic [perf_cnt_pkg::CNT_NB-1:0]                     load;
  logic [perf_cnt_pkg::CNT_NB-1:0]                     carry; // slices -> front
  logic                                                carry_any;
  perf_cnt_pkg::cnt_data_t                             load_data;
  perf_cnt_pkg::cnt_data_t [perf_cnt_pkg::CNT_NB-1:0]  slot_value;

  // only the LOW slot ever raises its carry
  assign carry_any = |carry;

  perf_cnt_front front0 (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .evt_i       (evt_i),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .carry_i     (carry_any),
    .inc_o       (inc),
    .load_o      (load),
    .load_data_o (load_data)
  );

  // ----------------------------------------
  // counter slots
  // ----------------------------------------
  for (genvar gi = 0; gi < perf_cnt_pkg::CNT_NB; gi++) begin : gen_slice
    perf_cnt_slice #(
      .MODE (perf_cnt_pkg::CNT_MODE[gi]),
      .IDX  (gi)
    ) slice0 (
      .clk         (clk),
      .s_rst_n     (s_rst_n),
      .inc_i       (inc[gi]),
      .load_i      (load[gi]),
      .load_data_i (load_data),
      .value_o     (slot_value[gi]),
      .carry_o     (carry[gi])
    );
  end

  perf_cnt_readback rdbk0 (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .slot_value_i (slot_value),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .rd_valid_o   (rd_valid_o)
  );

endmodule

// ==== bench/perf_cnt_check.svh ====
`ifndef PERF_CNT_CHECK_SVH
`define PERF_CNT_CHECK_SVH

// ----------------------------------------
// result checks, first error ends the run
// ----------------------------------------

bit failed   = 1'b0; // some check went wrong
int n_checks = 0;    // compares done so far

task automatic abort_run(input string why);
  failed = 1'b1;
  $display("%s", why);
  $display("Test FAILED");
  $fatal(1, "run stopped at %0t", $time);
endtask

// register read data
task automatic check_data(
  input string                   name,
  input perf_cnt_pkg::cnt_data_t exp_val,
  input perf_cnt_pkg::cnt_data_t act_val
);
  n_checks++;
  if (act_val !== exp_val) begin
    abort_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                        $time, name, exp_val, act_val));
  end
endtask

// single flag, X counts as wrong
task automatic check_valid(
  input string name,
  input bit    exp_val,
  input logic  act_val
);
  n_checks++;
  if (act_val !== exp_val) begin
    abort_run($sformatf("mismatch at %0t: %s expected %b, got %b",
                        $time, name, exp_val, act_val));
  end
endtask

`endif

// ==== bench/perf_cnt_tb.sv ====
`timescale 1ns/10ps

module perf_cnt_tb;

  localparam int    CLK_PERIOD = 20; // ns
  localparam int    RST_CYCLES = 3;
  localparam int    SEED_INIT  = 66;
  localparam string CMD_FILE   = "bench/perf_cnt_input.txt";

  // parsed command codes
  localparam int OP_EVT    = 0; // hold an event mask
  localparam int OP_WR     = 1;
  localparam int OP_RD     = 2;
  localparam int OP_IDLE   = 3;
  localparam int OP_PULSES = 4; // single high cycles, random gaps
  localparam int OP_RUNS   = 5; // separate levels, random lengths

  logic                            clk = 1'b0;
  logic                            s_rst_n;
  logic [perf_cnt_pkg::EVT_NB-1:0] evt_i;
  logic                            wr_en_i;
  perf_cnt_pkg::cnt_addr_t         wr_addr_i;
  perf_cnt_pkg::cnt_data_t         wr_data_i;
  logic                            rd_en_i;
  perf_cnt_pkg::cnt_addr_t         rd_addr_i;
  perf_cnt_pkg::cnt_data_t         rd_data_o;
  logic                            rd_valid_o;

  int          seed = SEED_INIT;
  int          op_q[$];           // command list
  logic [31:0] arg_a_q[$];
  logic [31:0] arg_b_q[$];
  int          cycle_budget;      // worst case length of the list
  bit          parse_done = 1'b0;

  `include "perf_cnt_check.svh"

  perf_cnt_top dut0 (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .evt_i      (evt_i),
    .wr_en_i    (wr_en_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .rd_en_i    (rd_en_i),
    .rd_addr_i  (rd_addr_i),
    .rd_data_o  (rd_data_o),
    .rd_valid_o (rd_valid_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // one clock, inputs move 1 ns after the edge
  task automatic tick();
    logic rd_was; // strobe seen by this edge
    rd_was = rd_en_i;
    @(posedge clk);
    #1;
    check_valid("rd_valid_o", rd_was, rd_valid_o); // valid trails strobe
  endtask

  // ----------------------------------------
  // command file
  // ----------------------------------------
  task automatic load_commands();
    int               fd;
    int               got;
    int               op;
    logic [8*8-1:0]   word; // command name
    logic [8*128-1:0] rest; // comment text
    logic [31:0]      a;
    logic [31:0]      b;
    cycle_budget = RST_CYCLES + 2;
    fd = $fopen(CMD_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open the command file %s", CMD_FILE));
    end
    while ($fscanf(fd, "%s", word) == 1) begin
      b = '0;
      if (word == 64'("#")) begin
        got = $fgets(rest, fd);
        continue;
      end
      if (word == 64'("evt")) begin
        op  = OP_EVT;
        got = $fscanf(fd, "%h %d", a, b); // mask, cycles
      end else if (word == 64'("wr") || word == 64'("rd")) begin
        op  = (word == 64'("wr")) ? OP_WR : OP_RD;
        got = $fscanf(fd, "%d %h", a, b); // slot, value
      end else if (word == 64'("idle")) begin
        op  = OP_IDLE;
        got = $fscanf(fd, "%d", a) + 1;
      end else if (word == 64'("pulses") || word == 64'("runs")) begin
        op  = (word == 64'("pulses")) ? OP_PULSES : OP_RUNS;
        got = $fscanf(fd, "%d %d", a, b); // line, count
      end else begin
        abort_run($sformatf("unknown command %0s in %s", word, CMD_FILE));
      end
      if (got != 2) begin
        abort_run($sformatf("unreadable arguments after %0s in %s", word, CMD_FILE));
      end
      case (op)
        OP_EVT:    cycle_budget += b;
        OP_IDLE:   cycle_budget += a;
        OP_PULSES: cycle_budget += 3 * b; // high + up to 2 low
        OP_RUNS:   cycle_budget += 7 * b; // up to 4 high + 3 low
        default:   cycle_budget += 1;
      endcase
      op_q.push_back(op);
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // command execution
  // ----------------------------------------
  task automatic run_command(input int op, input logic [31:0] a, input logic [31:0] b);
    int gap;
    int len;
    case (op)
      OP_EVT: begin
        evt_i = a[perf_cnt_pkg::EVT_NB-1:0]; // held until next evt
        repeat (b) tick();
      end
      OP_WR: begin
        wr_en_i   = 1'b1;
        wr_addr_i = a[perf_cnt_pkg::ADDR_W-1:0];
        wr_data_i = b;
        tick();
        wr_en_i   = 1'b0;
      end
      OP_RD: begin
        rd_en_i   = 1'b1;
        rd_addr_i = a[perf_cnt_pkg::ADDR_W-1:0];
        tick();
        rd_en_i   = 1'b0;
        check_data($sformatf("rd_data_o slot %0d", a), b, rd_data_o);
      end
      OP_IDLE: repeat (a) tick();
      OP_PULSES: begin
        repeat (b) begin
          evt_i[a[2:0]] = 1'b1;
          tick();
          evt_i[a[2:0]] = 1'b0;
          gap = int'($unsigned($random(seed)) % 3); // 0..2 low cycles
          repeat (gap) tick();
        end
      end
      OP_RUNS: begin
        repeat (b) begin
          len = int'(1 + $unsigned($random(seed)) % 4);
          gap = int'(1 + $unsigned($random(seed)) % 3); // always a low gap
          evt_i[a[2:0]] = 1'b1;
          repeat (len) tick();
          evt_i[a[2:0]] = 1'b0;
          repeat (gap) tick();
        end
      end
      default: abort_run($sformatf("bad command code %0d", op));
    endcase
  endtask

  initial begin
    int i;
    s_rst_n   = 1'b0;
    evt_i     = '0;
    wr_en_i   = 1'b0;
    wr_addr_i = '0;
    wr_data_i = '0;
    rd_en_i   = 1'b0;
    rd_addr_i = '0;
    load_commands();
    parse_done = 1'b1;
    repeat (RST_CYCLES) tick();
    s_rst_n = 1'b1;
    for (i = 0; i < op_q.size(); i++) begin
      run_command(op_q[i], arg_a_q[i], arg_b_q[i]);
    end
    tick(); // last valid drops
    if (!failed) begin
      $display("%0d commands, %0d checks", op_q.size(), n_checks);
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "checks failed");
    end
  end

  // watchdog, twice the worst case length
  initial begin
    wait (parse_done);
    #(2 * cycle_budget * CLK_PERIOD);
    abort_run($sformatf("watchdog expired, run longer than %0d cycles", 2 * cycle_budget));
  end

endmodule

// ==== build.f ====
+incdir+bench
rtl/perf_cnt_pkg.sv
rtl/perf_cnt_front.sv
rtl/perf_cnt_slice.sv
rtl/perf_cnt_readback.sv
rtl/perf_cnt_top.sv
bench/perf_cnt_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = perf_cnt_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/perf_cnt_input.txt ====
# one command per line, slots and cycle counts decimal, masks and values hex
# evt <mask> <cycles> | wr <slot> <value> | rd <slot> <expected> | idle <cycles>
# pulses <line> <high cycles> | runs <line> <levels> with random gaps
# every slot reads zero after reset
rd 0 00000000
rd 1 00000000
rd 2 00000000
rd 3 00000000
rd 4 00000000
rd 5 00000000
# PULSE slot 0, 9 high cycles then 12 scattered ones
evt 01 9
evt 00 2
rd 0 00000009
pulses 0 12
idle 2
rd 0 00000015
# EDGE slot 1, 6 random levels then one long level
runs 1 6
idle 2
rd 1 00000006
evt 02 10
evt 00 2
rd 1 00000007
# DURATION slot 2, runs of 3, 7 and 5 keep 7
evt 04 3
evt 00 2
evt 04 7
evt 00 2
evt 04 5
evt 00 3
rd 2 00000007
# load the max with 2, a run of 4 beats it
wr 2 00000002
evt 04 4
evt 00 3
rd 2 00000004
# slot 0 one below full, three counts stick at all ones
wr 0 fffffffe
evt 01 3
evt 00 2
rd 0 ffffffff
# write and event in the same cycle
evt 01 0
wr 0 00000010
evt 00 3
rd 0 00000010
# 64-bit pair, low half wraps and carries once
wr 3 fffffffe
wr 4 00000005
idle 2
evt 08 4
evt 00 3
rd 3 00000002
rd 4 00000006
